//--- Bender.yml
package:
  name: ex_mem_subsystem

sources:
  - source/cpu_types_pkg.sv
  - source/pipe_ctrl_pkg.sv
  - source/ex_mem_if.sv
  - source/execute_stage.sv
  - source/ex_mem_latch.sv
  - source/memory_stage.sv
  - source/ex_mem_subsystem.sv
  - target: test
    files:
      - bench/ex_mem_checker.sv
      - bench/ex_mem_subsystem_tb.sv

//--- bench/ex_mem_checker.sv
`timescale 1ns/1ns

module ex_mem_checker
   import cpu_types_pkg::*;
(
   input logic     CLK,
   input logic     nRST,
   input logic     active,
   input logic     stall,
   input logic     wb_en,
   input regbits_t wb_reg,
   input word_t    wb_data,
   input logic     branch_taken,
   input logic     halt
);

   logic     q_en [$];
   regbits_t q_reg [$];
   word_t    q_data [$];
   logic     q_br [$];
   logic     q_halt [$];
   int       q_stalls [$];

   int error_count = 0;
   int stall_run   = 0; // Stall cycles seen before the current writeback

   task automatic expect_wb(input logic en, input regbits_t rg, input word_t data,
                            input logic br, input logic hlt, input int stalls);
      q_en.push_back(en);
      q_reg.push_back(rg);
      q_data.push_back(data);
      q_br.push_back(br);
      q_halt.push_back(hlt);
      q_stalls.push_back(stalls);
   endtask

   function automatic int pending_count();
      return q_en.size();
   endfunction

   task automatic report_mismatch(input string field, input word_t exp, input word_t got);
      error_count++;
      $display("[ERROR] %0t ns: %s expected %h got %h", $time, field, exp, got);
   endtask

   always @(negedge CLK) begin
      logic     e_en;
      regbits_t e_reg;
      word_t    e_data;
      logic     e_br;
      logic     e_halt;
      int       e_stalls;
      if (nRST && active) begin
         if (stall) begin
            stall_run++;
            if (wb_en)
               report_mismatch("wb_en during stall", 0, wb_en);
         end else if (q_en.size() == 0) begin
            error_count++;
            $display("%0t ns: a writeback cycle came with no instruction outstanding", $time);
         end else begin
            e_en     = q_en.pop_front();
            e_reg    = q_reg.pop_front();
            e_data   = q_data.pop_front();
            e_br     = q_br.pop_front();
            e_halt   = q_halt.pop_front();
            e_stalls = q_stalls.pop_front();
            if (stall_run != e_stalls)
               report_mismatch("stall cycles", e_stalls, stall_run);
            if (wb_en !== e_en)
               report_mismatch("wb_en", e_en, wb_en);
            if (e_en && wb_reg !== e_reg)
               report_mismatch("wb_reg", e_reg, wb_reg);
            if (e_en && wb_data !== e_data)
               report_mismatch("wb_data", e_data, wb_data);
            if (branch_taken !== e_br)
               report_mismatch("branch_taken", e_br, branch_taken);
            if (halt !== e_halt)
               report_mismatch("halt", e_halt, halt);
            stall_run = 0;
         end
      end
   end

endmodule

//--- bench/ex_mem_subsystem_tb.sv
`timescale 1ns/1ns

module ex_mem_subsystem_tb
   import cpu_types_pkg::*;
   import pipe_ctrl_pkg::*;
();

   localparam int N_RANDOM    = 200;
   localparam int N_DIRECTED  = 11;
   localparam int TIMEOUT_CYC = (N_RANDOM + N_DIRECTED + 1) * (DMEM_WAIT + 3) + 50;

   logic CLK = 1'b0;
   logic nRST;
   logic active;
   aluop_t alu_op;
   word_t rdat1, rdat2, npc;
   imm16_t imm16;
   logic [4:0] shamt;
   logic sign_ext, alu_src_imm, regwrite, dmem_ren, dmem_wen, branch_select, halt_in;
   memtoreg_t memtoreg;
   pcsel_t pcselect;
   regbits_t dest;
   jaddr_t jaddr;
   logic stall, wb_en, branch_taken, halt;
   regbits_t wb_reg;
   word_t wb_data;

   // Next instruction, built by the generators and applied by issue
   aluop_t nx_op;
   word_t nx_rdat1, nx_rdat2, nx_npc;
   imm16_t nx_imm;
   logic [4:0] nx_shamt;
   logic nx_sext, nx_src_imm, nx_rw, nx_ren, nx_wen, nx_br, nx_halt;
   memtoreg_t nx_mtr;
   pcsel_t nx_pcsel;
   regbits_t nx_dest;
   jaddr_t nx_jaddr;

   word_t shadow [DMEM_WORDS]; // Expected data memory contents
   logic last_mem;

   always #10 CLK = ~CLK;

   ex_mem_subsystem UUT (
      .CLK(CLK), .nRST(nRST), .alu_op(alu_op), .rdat1(rdat1), .rdat2(rdat2), .npc(npc),
      .imm16(imm16), .shamt(shamt), .sign_ext(sign_ext), .alu_src_imm(alu_src_imm),
      .memtoreg(memtoreg), .regwrite(regwrite), .dmem_ren(dmem_ren), .dmem_wen(dmem_wen),
      .branch_select(branch_select), .halt_in(halt_in), .pcselect(pcselect), .dest(dest),
      .jaddr(jaddr), .stall(stall), .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data),
      .branch_taken(branch_taken), .halt(halt)
   );

   ex_mem_checker CHK (
      .CLK(CLK), .nRST(nRST), .active(active), .stall(stall), .wb_en(wb_en),
      .wb_reg(wb_reg), .wb_data(wb_data), .branch_taken(branch_taken), .halt(halt)
   );

   function automatic word_t alu_ref(aluop_t op, word_t a, word_t b, logic [4:0] sh);
      case (op)
         ALU_ADD:  return a + b;
         ALU_SUB:  return a - b;
         ALU_AND:  return a & b;
         ALU_OR:   return a | b;
         ALU_XOR:  return a ^ b;
         ALU_NOR:  return ~(a | b);
         ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
         ALU_SLL:  return b << sh; // Shifts work on the second operand
         ALU_SRL:  return b >> sh;
         default:  return '0;
      endcase
   endfunction

   task automatic set_nop();
      nx_op = ALU_ADD;
      {nx_rdat1, nx_rdat2, nx_npc, nx_imm, nx_shamt, nx_dest, nx_jaddr} = '0;
      {nx_sext, nx_src_imm, nx_rw, nx_ren, nx_wen, nx_br, nx_halt} = '0;
      nx_mtr   = WB_ALU;
      nx_pcsel = PC_SEQ;
   endtask

   task automatic set_mem(input logic store, input logic [5:0] idx, input word_t data);
      set_nop();
      nx_src_imm = 1'b1;
      nx_sext    = $urandom;
      nx_imm     = {8'h00, idx, 2'b00};
      nx_dest    = 5'd9;
      nx_rdat2   = data;
      if (store) begin
         nx_wen = 1'b1;
      end else begin
         nx_ren = 1'b1;
         nx_rw  = 1'b1;
         nx_mtr = WB_MEM;
      end
   endtask

   task automatic gen_random(input logic allow_mem);
      int kind;
      int m;
      kind = $urandom % 10;
      if (allow_mem && kind < 3) begin
         set_mem(kind == 0, $urandom % 8, $urandom); // Few addresses so loads hit stores
      end else begin
         set_nop();
         nx_op      = aluop_t'($urandom % 10);
         nx_rdat1   = $urandom;
         nx_rdat2   = (($urandom % 4) == 0) ? nx_rdat1 : $urandom;
         nx_npc     = $urandom;
         nx_imm     = $urandom;
         nx_shamt   = $urandom;
         nx_sext    = $urandom;
         nx_src_imm = $urandom;
         nx_dest    = $urandom;
         nx_jaddr   = $urandom;
         m          = $urandom % 4;
         nx_mtr     = (m == 1) ? WB_ALU : memtoreg_t'(m);
         nx_rw      = ($urandom % 4) != 0;
         nx_br      = $urandom;
         nx_pcsel   = pcsel_t'($urandom % 4);
         nx_halt    = ($urandom % 16) == 0;
      end
   endtask

   // Called on a rising edge; returns on the edge where the next one may enter
   task automatic issue();
      word_t ext, opb, res, data;
      logic br;
      logic [DMEM_AW-1:0] idx;
      ext  = nx_sext ? {{16{nx_imm[15]}}, nx_imm} : {16'h0000, nx_imm};
      opb  = nx_src_imm ? ext : nx_rdat2;
      res  = alu_ref(nx_op, nx_rdat1, opb, nx_shamt);
      idx  = res[DMEM_AW+1:2];
      case (nx_mtr)
         WB_MEM:   data = shadow[idx];
         WB_NPC:   data = nx_npc;
         WB_UPPER: data = {nx_imm, 16'h0000};
         default:  data = res;
      endcase
      br = nx_br && (nx_pcsel == PC_BRANCH) && (res == '0);
      CHK.expect_wb(nx_rw, nx_dest, data, br, nx_halt, (nx_ren || nx_wen) ? DMEM_WAIT + 1 : 0);
      if (nx_wen)
         shadow[idx] = nx_rdat2;
      alu_op <= nx_op; rdat1 <= nx_rdat1; rdat2 <= nx_rdat2; npc <= nx_npc;
      imm16 <= nx_imm; shamt <= nx_shamt; sign_ext <= nx_sext; alu_src_imm <= nx_src_imm;
      memtoreg <= nx_mtr; regwrite <= nx_rw; dmem_ren <= nx_ren; dmem_wen <= nx_wen;
      branch_select <= nx_br; halt_in <= nx_halt; pcselect <= nx_pcsel;
      dest <= nx_dest; jaddr <= nx_jaddr;
      @(posedge CLK);
      if (nx_ren || nx_wen)
         repeat (DMEM_WAIT + 1) @(posedge CLK); // Access completes at the hit
   endtask

   initial begin
      repeat (TIMEOUT_CYC) @(posedge CLK);
      $display("Run stopped: simulation timed out after %0d cycles", TIMEOUT_CYC);
      $display("Checks done with %0d errors", CHK.error_count);
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin
      void'($urandom(21615));
      for (int i = 0; i < DMEM_WORDS; i++)
         shadow[i] = '0;
      nRST   <= 1'b0;
      active <= 1'b0;
      set_nop();
      alu_op <= ALU_ADD; {rdat1, rdat2, npc, imm16, shamt, dest, jaddr} <= '0;
      {sign_ext, alu_src_imm, regwrite, dmem_ren, dmem_wen, branch_select, halt_in} <= '0;
      memtoreg <= WB_ALU;
      pcselect <= PC_SEQ;
      repeat (3) @(posedge CLK);
      nRST   <= 1'b1;
      active <= 1'b1;
      CHK.expect_wb(1'b0, '0, '0, 1'b0, 1'b0, 0); // Idle cycle straight after reset

      set_mem(1'b0, 6'd5, '0); issue();  // Unwritten word reads zero
      set_nop(); issue();
      set_mem(1'b1, 6'd5, 32'hCAFE_F00D); issue();
      set_nop(); issue();
      set_mem(1'b0, 6'd5, '0); issue();
      set_nop(); nx_rw = 1'b1; nx_mtr = WB_NPC; nx_npc = 32'h0040_0124; nx_dest = 5'd31;
      issue();
      set_nop(); nx_rw = 1'b1; nx_mtr = WB_UPPER; nx_imm = 16'h1234; nx_dest = 5'd4;
      issue();
      set_nop(); nx_op = ALU_SUB; nx_rdat1 = 32'd77; nx_rdat2 = 32'd77;
      nx_br = 1'b1; nx_pcsel = PC_BRANCH;
      issue();
      nx_rdat2 = 32'd78;
      issue();
      set_nop(); nx_halt = 1'b1; issue();
      set_nop(); issue();

      last_mem = 1'b0;
      for (int i = 0; i < N_RANDOM; i++) begin
         gen_random(!last_mem);
         last_mem = nx_ren || nx_wen;
         issue();
      end

      set_nop(); issue();
      while (CHK.pending_count() > 0)
         @(posedge CLK);
      active <= 1'b0;
      @(posedge CLK);
      $display("Checks done with %0d errors", CHK.error_count);
      if (CHK.error_count == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

//--- ex_mem_subsystem.f
source/cpu_types_pkg.sv
source/pipe_ctrl_pkg.sv
source/ex_mem_if.sv
source/execute_stage.sv
source/ex_mem_latch.sv
source/memory_stage.sv
source/ex_mem_subsystem.sv
bench/ex_mem_checker.sv
bench/ex_mem_subsystem_tb.sv

//--- source/cpu_types_pkg.sv
package cpu_types_pkg;

   localparam int WORD_W  = 32;
   localparam int REG_W   = 5;
   localparam int IMM_W   = 16;
   localparam int JADDR_W = 26;
   localparam int ALUOP_W = 4;

   typedef logic [WORD_W-1:0]  word_t;    // Datapath word
   typedef logic [REG_W-1:0]   regbits_t; // Register file index
   typedef logic [IMM_W-1:0]   imm16_t;   // I-type immediate
   typedef logic [JADDR_W-1:0] jaddr_t;   // J-type target field
   typedef logic [ALUOP_W-1:0] aluop_t;

   localparam aluop_t ALU_ADD  = 4'd0;
   localparam aluop_t ALU_SUB  = 4'd1;
   localparam aluop_t ALU_AND  = 4'd2;
   localparam aluop_t ALU_OR   = 4'd3;
   localparam aluop_t ALU_XOR  = 4'd4;
   localparam aluop_t ALU_NOR  = 4'd5;
   localparam aluop_t ALU_SLT  = 4'd6;  // Signed compare
   localparam aluop_t ALU_SLTU = 4'd7;  // Unsigned compare
   localparam aluop_t ALU_SLL  = 4'd8;  // Shift by shamt
   localparam aluop_t ALU_SRL  = 4'd9;

endpackage

//--- source/ex_mem_if.sv
`timescale 1ns/1ns

interface ex_mem_if
   import cpu_types_pkg::*;
   import pipe_ctrl_pkg::*;
();

   memtoreg_t memtoreg;
   logic      regwrite;
   pcsel_t    pcselect;
   logic      branchSelect;
   logic      dmemREN;
   logic      dmemWEN;
   logic      halt;
   word_t     rdat1;
   word_t     rdat2;   // Store data
   word_t     npc;
   logic      zeroFlag;
   word_t     aluResult; // Also the memory byte address
   regbits_t  branchDest;
   word_t     upper16;
   word_t     signZero;
   jaddr_t    iMemLoad;

   modport producer (
      output memtoreg, regwrite, pcselect, branchSelect,
      output dmemREN, dmemWEN, halt,
      output rdat1, rdat2, npc, zeroFlag, aluResult,
      output branchDest, upper16, signZero, iMemLoad
   );

   modport consumer (
      input memtoreg, regwrite, pcselect, branchSelect,
      input dmemREN, dmemWEN, halt,
      input rdat1, rdat2, npc, zeroFlag, aluResult,
      input branchDest, upper16, signZero, iMemLoad
   );

endinterface

//--- source/ex_mem_latch.sv
`timescale 1ns/1ns

module ex_mem_latch (
   input  logic       CLK,
   input  logic       nRST,
   ex_mem_if.consumer ex,
   ex_mem_if.producer mem,
   input  logic       dhit,
   output logic       stall
);

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         mem.memtoreg     <= '0;
         mem.regwrite     <= 1'b0;
         mem.pcselect     <= '0;
         mem.branchSelect <= 1'b0;
         mem.dmemREN      <= 1'b0;
         mem.dmemWEN      <= 1'b0;
         mem.halt         <= 1'b0;
         mem.rdat1        <= '0;
         mem.rdat2        <= '0;
         mem.npc          <= '0;
         mem.zeroFlag     <= 1'b0;
         mem.aluResult    <= '0;
         mem.branchDest   <= '0;
         mem.upper16      <= '0;
         mem.signZero     <= '0;
         mem.iMemLoad     <= '0;
      end else begin
         mem.dmemREN      <= dhit ? 1'b0 : ex.dmemREN; // Drop strobes once served
         mem.dmemWEN      <= dhit ? 1'b0 : ex.dmemWEN;
         mem.memtoreg     <= ex.memtoreg;
         mem.regwrite     <= ex.regwrite;
         mem.pcselect     <= ex.pcselect;
         mem.branchSelect <= ex.branchSelect;
         mem.halt         <= ex.halt;
         mem.rdat1        <= ex.rdat1;
         mem.rdat2        <= ex.rdat2;
         mem.npc          <= ex.npc;
         mem.zeroFlag     <= ex.zeroFlag;
         mem.aluResult    <= ex.aluResult;
         mem.branchDest   <= ex.branchDest;
         mem.upper16      <= ex.upper16;
         mem.signZero     <= ex.signZero;
         mem.iMemLoad     <= ex.iMemLoad;
      end
   end

   assign stall = (mem.dmemREN || mem.dmemWEN) && !dhit; // Request still outstanding

   a_no_rw_together : assert property (
      @(posedge CLK) disable iff (!nRST)
      !(ex.dmemREN && ex.dmemWEN))
      else $error("ex_mem_latch: read and write requested together");

   // An access arriving while the previous one completes would lose its strobe
   a_no_req_on_hit : assert property (
      @(posedge CLK) disable iff (!nRST)
      dhit |-> !(ex.dmemREN || ex.dmemWEN))
      else $error("ex_mem_latch: memory request on a dhit cycle");

endmodule

//--- source/ex_mem_subsystem.sv
`timescale 1ns/1ns

module ex_mem_subsystem
   import cpu_types_pkg::*;
   import pipe_ctrl_pkg::*;
(
   input  logic       CLK,
   input  logic       nRST,
   input  aluop_t     alu_op,
   input  word_t      rdat1,
   input  word_t      rdat2,
   input  word_t      npc,
   input  imm16_t     imm16,
   input  logic [4:0] shamt,
   input  logic       sign_ext,
   input  logic       alu_src_imm,
   input  memtoreg_t  memtoreg,
   input  logic       regwrite,
   input  logic       dmem_ren,
   input  logic       dmem_wen,
   input  logic       branch_select,
   input  logic       halt_in,
   input  pcsel_t     pcselect,
   input  regbits_t   dest,
   input  jaddr_t     jaddr,
   output logic       stall,
   output logic       wb_en,
   output regbits_t   wb_reg,
   output word_t      wb_data,
   output logic       branch_taken,
   output logic       halt
);

   logic dhit;

   ex_mem_if ex_bus ();
   ex_mem_if mem_bus ();

   execute_stage u_execute (
      .alu_op        (alu_op),
      .rdat1         (rdat1),
      .rdat2         (rdat2),
      .npc           (npc),
      .imm16         (imm16),
      .shamt         (shamt),
      .sign_ext      (sign_ext),
      .alu_src_imm   (alu_src_imm),
      .memtoreg      (memtoreg),
      .regwrite      (regwrite),
      .dmem_ren      (dmem_ren),
      .dmem_wen      (dmem_wen),
      .branch_select (branch_select),
      .halt          (halt_in),
      .pcselect      (pcselect),
      .dest          (dest),
      .jaddr         (jaddr),
      .ex            (ex_bus.producer)
   );

   ex_mem_latch u_latch (
      .CLK   (CLK),
      .nRST  (nRST),
      .ex    (ex_bus.consumer),
      .mem   (mem_bus.producer),
      .dhit  (dhit),
      .stall (stall)
   );

   memory_stage u_memory (
      .CLK          (CLK),
      .nRST         (nRST),
      .mem          (mem_bus.consumer),
      .dhit         (dhit),
      .wb_en        (wb_en),
      .wb_reg       (wb_reg),
      .wb_data      (wb_data),
      .branch_taken (branch_taken),
      .halt         (halt)
   );

endmodule

//--- source/execute_stage.sv
`timescale 1ns/1ns

module execute_stage
   import cpu_types_pkg::*;
   import pipe_ctrl_pkg::*;
(
   input  aluop_t    alu_op,
   input  word_t     rdat1,
   input  word_t     rdat2,
   input  word_t     npc,
   input  imm16_t    imm16,
   input  logic [4:0] shamt,
   input  logic      sign_ext,
   input  logic      alu_src_imm,
   input  memtoreg_t memtoreg,
   input  logic      regwrite,
   input  logic      dmem_ren,
   input  logic      dmem_wen,
   input  logic      branch_select,
   input  logic      halt,
   input  pcsel_t    pcselect,
   input  regbits_t  dest,
   input  jaddr_t    jaddr,
   ex_mem_if.producer ex
);

   word_t imm_ext;
   word_t operand_b;
   word_t alu_out;
   logic  op_known;

   assign imm_ext   = sign_ext ? {{16{imm16[15]}}, imm16} : {16'h0000, imm16};
   assign operand_b = alu_src_imm ? imm_ext : rdat2;

   always_comb begin
      op_known = 1'b1;
      case (alu_op)
         ALU_ADD:  alu_out = rdat1 + operand_b;
         ALU_SUB:  alu_out = rdat1 - operand_b;
         ALU_AND:  alu_out = rdat1 & operand_b;
         ALU_OR:   alu_out = rdat1 | operand_b;
         ALU_XOR:  alu_out = rdat1 ^ operand_b;
         ALU_NOR:  alu_out = ~(rdat1 | operand_b);
         ALU_SLT:  alu_out = {31'b0, $signed(rdat1) < $signed(operand_b)};
         ALU_SLTU: alu_out = {31'b0, rdat1 < operand_b};
         ALU_SLL:  alu_out = operand_b << shamt; // Shifts act on rt
         ALU_SRL:  alu_out = operand_b >> shamt;
         default: begin
            alu_out  = '0;
            op_known = 1'b0;
         end
      endcase
   end

   always_comb begin
      assert final ($isunknown(alu_op) || op_known)
         else $error("execute_stage: undefined alu_op %0d", alu_op);
   end

   assign ex.aluResult    = alu_out;
   assign ex.zeroFlag     = (alu_out == '0);
   assign ex.signZero     = imm_ext;
   assign ex.upper16      = {imm16, 16'h0000};
   assign ex.rdat1        = rdat1;
   assign ex.rdat2        = rdat2;
   assign ex.npc          = npc;
   assign ex.memtoreg     = memtoreg;
   assign ex.regwrite     = regwrite;
   assign ex.pcselect     = pcselect;
   assign ex.branchSelect = branch_select;
   assign ex.dmemREN      = dmem_ren;
   assign ex.dmemWEN      = dmem_wen;
   assign ex.halt         = halt;
   assign ex.branchDest   = dest;
   assign ex.iMemLoad     = jaddr;

endmodule

//--- source/memory_stage.sv
`timescale 1ns/1ns

module memory_stage
   import cpu_types_pkg::*;
   import pipe_ctrl_pkg::*;
(
   input  logic       CLK,
   input  logic       nRST,
   ex_mem_if.consumer mem,
   output logic       dhit,
   output logic       wb_en,
   output regbits_t   wb_reg,
   output word_t      wb_data,
   output logic       branch_taken,
   output logic       halt
);

   word_t                   dmem [DMEM_WORDS];
   logic [DMEM_AW-1:0]      addr;
   logic [DMEM_WAIT_CW-1:0] wait_cnt;
   mem_state_t              state;
   mem_state_t              next_state;
   logic                    req;
   logic                    pending;

   assign addr    = mem.aluResult[DMEM_AW+1:2]; // Word address
   assign req     = mem.dmemREN || mem.dmemWEN;
   assign pending = req && !dhit;

   always_comb begin
      next_state = state;
      case (state)
         MS_IDLE: begin
            if (req)
               next_state = MS_WAIT;
         end
         MS_WAIT: begin
            if (!req)
               next_state = MS_IDLE;
            else if (wait_cnt == DMEM_WAIT_CW'(DMEM_WAIT - 1))
               next_state = MS_HIT;
         end
         MS_HIT:  next_state = MS_IDLE; // One hit cycle per access
         default: next_state = MS_IDLE;
      endcase
   end

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         state    <= MS_IDLE;
         wait_cnt <= '0;
         dhit     <= 1'b0;
      end else begin
         state    <= next_state;
         wait_cnt <= (state == MS_WAIT) ? wait_cnt + 1'b1 : '0;
         dhit     <= (next_state == MS_HIT);
      end
   end

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         for (int i = 0; i < DMEM_WORDS; i++)
            dmem[i] <= '0;
      end else if (state == MS_HIT && mem.dmemWEN) begin
         dmem[addr] <= mem.rdat2;
      end
   end

   always_comb begin
      case (mem.memtoreg)
         WB_MEM:   wb_data = dmem[addr];
         WB_NPC:   wb_data = mem.npc;
         WB_UPPER: wb_data = mem.upper16;
         default:  wb_data = mem.aluResult;
      endcase
   end

   assign wb_en        = mem.regwrite && !pending; // Once, when the op retires
   assign wb_reg       = mem.branchDest;
   assign branch_taken = mem.branchSelect && (mem.pcselect == PC_BRANCH) && mem.zeroFlag;
   assign halt         = mem.halt;

   // A hit only completes an access that is still requested
   a_dhit_in_hit : assert property (
      @(posedge CLK) disable iff (!nRST)
      dhit |-> (state == MS_HIT) && req)
      else $error("memory_stage: dhit outside MS_HIT or without a request");

   // The upstream stage must hold a waiting access steady
   a_addr_held : assert property (
      @(posedge CLK) disable iff (!nRST)
      pending |=> $stable(addr))
      else $error("memory_stage: address changed while stalled");

endmodule

//--- source/pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

   typedef logic [1:0] memtoreg_t;
   typedef logic [1:0] pcsel_t;

   localparam memtoreg_t WB_ALU   = 2'd0;
   localparam memtoreg_t WB_MEM   = 2'd1; // Loaded word
   localparam memtoreg_t WB_NPC   = 2'd2; // Link address
   localparam memtoreg_t WB_UPPER = 2'd3; // lui value

   localparam pcsel_t PC_SEQ    = 2'd0;
   localparam pcsel_t PC_BRANCH = 2'd1;
   localparam pcsel_t PC_JUMP   = 2'd2;
   localparam pcsel_t PC_JR     = 2'd3;

   localparam int DMEM_WORDS   = 64;
   localparam int DMEM_AW      = 6;
   localparam int DMEM_WAIT    = 2;  // Wait cycles before dhit
   localparam int DMEM_WAIT_CW = $clog2(DMEM_WAIT + 1);

   typedef enum logic [1:0] {
      MS_IDLE,
      MS_WAIT,
      MS_HIT
   } mem_state_t;

endpackage
